/* Bender.yml */
package:
  name: fetch_stage

sources:
  # package first, then the RTL from leaves to top
  - fetch_pkg.sv
  - slot_predecode.sv
  - branch_history_table.sv
  - next_pc_select.sv
  - fetch_stage.sv
  - target: test
    files:
      - fetch_stage_checker.sv
      - fetch_stage_tb.sv

/* branch_history_table.sv */
////////////////////////////////////////
// branch history table
// two-bit saturating counters, two read
// ports for fetch, one resolve update
////////////////////////////////////////

`timescale 1ns/10ps

module branch_history_table (
	input  logic                   clock,
	input  logic                   reset,
	input  fetch_pkg::addr_t       pc0,      // slot 0 branch address
	input  fetch_pkg::addr_t       pc1,      // slot 1 branch address
	input  fetch_pkg::bht_update_t update,   // resolve from execute
	output logic                   taken0,   // slot 0 prediction
	output logic                   taken1    // slot 1 prediction
);

	fetch_pkg::counter_t   counters [fetch_pkg::bht_entries];   // the table
	fetch_pkg::bht_index_t index0;
	fetch_pkg::bht_index_t index1;
	fetch_pkg::bht_index_t update_index;
	fetch_pkg::counter_t   current;      // counter being trained
	fetch_pkg::counter_t   next_count;   // after saturating step

	// word address bits, so neighbouring slots use neighbouring entries
	function automatic fetch_pkg::bht_index_t table_index(input fetch_pkg::addr_t addr);
		return addr[fetch_pkg::bht_index_bits+1:2];
	endfunction

	assign index0       = table_index(pc0);
	assign index1       = table_index(pc1);
	assign update_index = table_index(update.pc);

	////////////////////////////////////////
	// read ports
	////////////////////////////////////////
	assign taken0 = counters[index0][1];   // msb is the prediction
	assign taken1 = counters[index1][1];

	////////////////////////////////////////
	// update path
	////////////////////////////////////////
	assign current = counters[update_index];

	always_comb begin
		next_count = current;                           // saturated: hold
		if (update.taken) begin
			if (current != fetch_pkg::counter_max) begin
				next_count = current + 2'd1;            // towards taken
			end
		end else begin
			if (current != fetch_pkg::counter_min) begin
				next_count = current - 2'd1;            // towards not taken
			end
		end
	end

	// reads in the same cycle see the old counter
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < fetch_pkg::bht_entries; i++) begin
				counters[i] <= fetch_pkg::counter_reset;   // weakly not taken
			end
		end else if (update.valid) begin
			counters[update_index] <= next_count;
		end
	end

endmodule

/* fetch_pkg.sv */
////////////////////////////////////////
// fetch path shared definitions
// widths, opcodes, table size and the
// structs passed between fetch blocks
////////////////////////////////////////

package fetch_pkg;

	////////////////////////////////////////
	// sizes
	////////////////////////////////////////
	localparam int addr_bits      = 64;            // byte address width
	localparam int inst_bits      = 32;            // one instruction word
	localparam int disp_bits      = 21;            // branch displacement field
	localparam int bht_index_bits = 6;             // 64-entry table
	localparam int bht_entries    = 1 << bht_index_bits;

	// vector types
	typedef logic [addr_bits-1:0]      addr_t;            // pc, targets, memory address
	typedef logic [inst_bits-1:0]      inst_t;            // one instruction
	typedef logic [2*inst_bits-1:0]    mem_word_t;        // low half at even address
	typedef logic [1:0]                dispatch_count_t;  // 0, 1, 2 (3 counts as 2)
	typedef logic [bht_index_bits-1:0] bht_index_t;       // table index
	typedef logic [1:0]                counter_t;         // 0 strong nt .. 3 strong t

	localparam addr_t    inst_bytes    = 64'd4;     // bytes per instruction
	localparam counter_t counter_reset = 2'd1;      // weakly not taken
	localparam counter_t counter_min   = 2'd0;      // strongly not taken
	localparam counter_t counter_max   = 2'd3;      // strongly taken

	////////////////////////////////////////
	// opcodes, bits [31:26]
	////////////////////////////////////////
	localparam logic [5:0] op_br        = 6'h30;   // unconditional branch
	localparam logic [5:0] op_bsr       = 6'h34;   // branch to subroutine
	localparam logic [5:0] op_jsr_grp   = 6'h1A;   // jmp/jsr/ret group
	localparam logic [2:0] op_cond_grp0 = 3'd6;    // cond branch major groups
	localparam logic [2:0] op_cond_grp1 = 3'd7;

	// predecoder result for one slot
	typedef struct packed {
		logic  is_uncond;    // br or bsr
		logic  is_cond;      // conditional branch
		logic  is_jump;      // jump group
		addr_t disp_target;  // npc + disp*4
	} slot_decode_t;

	// one instruction handed to decode
	typedef struct packed {
		logic  valid;        // decode may take it
		inst_t inst;
		addr_t npc;          // address after this slot
		logic  pred_taken;
		addr_t pred_target;
		logic  cond_valid;   // valid conditional branch
	} fetch_slot_t;

	// branch resolution from execute
	typedef struct packed {
		logic  valid;        // one cycle per resolve
		addr_t pc;           // address of the branch
		logic  taken;        // actual direction
	} bht_update_t;

endpackage

/* fetch_stage.f */
fetch_pkg.sv
slot_predecode.sv
branch_history_table.sv
next_pc_select.sv
fetch_stage.sv
fetch_stage_checker.sv
fetch_stage_tb.sv

/* fetch_stage.sv */
////////////////////////////////////////
// fetch stage top
// two-wide fetch: predecode, history
// table and next pc around memory
////////////////////////////////////////

`timescale 1ns/10ps

module fetch_stage (
	input  logic                       clock,
	input  logic                       reset,
	output fetch_pkg::addr_t           imem_addr,       // aligned word address
	input  fetch_pkg::mem_word_t       imem_data,       // two instructions
	input  logic                       imem_valid,
	input  fetch_pkg::dispatch_count_t dispatch_count,  // decode capacity
	input  fetch_pkg::addr_t           jump_target0,    // target buffer, slot 0
	input  fetch_pkg::addr_t           jump_target1,    // target buffer, slot 1
	input  logic                       recover,
	input  fetch_pkg::addr_t           recover_addr,
	input  fetch_pkg::bht_update_t     resolve,         // counter training
	output fetch_pkg::fetch_slot_t     slot0,
	output fetch_pkg::fetch_slot_t     slot1
);

	fetch_pkg::addr_t        pc;
	fetch_pkg::addr_t        base0;      // address after slot 0
	fetch_pkg::addr_t        base1;      // address after slot 1
	fetch_pkg::inst_t        inst0;
	fetch_pkg::inst_t        inst1;
	fetch_pkg::slot_decode_t decode0;
	fetch_pkg::slot_decode_t decode1;
	logic                    taken0;
	logic                    taken1;

	////////////////////////////////////////
	// memory side
	////////////////////////////////////////
	assign imem_addr = {pc[63:3], 3'b000};   // 8-byte aligned

	// odd word starts on the high half, slot 1 is always the high half
	assign inst0 = pc[2] ? imem_data[63:32] : imem_data[31:0];
	assign inst1 = imem_data[63:32];

	assign base0 = pc + fetch_pkg::inst_bytes;
	assign base1 = base0 + fetch_pkg::inst_bytes;

	slot_predecode i_predecode0 (
		.inst   (inst0),
		.npc    (base0),
		.decode (decode0)
	);

	slot_predecode i_predecode1 (
		.inst   (inst1),
		.npc    (base1),
		.decode (decode1)
	);

	// indexed by the slot's own address, pc and pc+4
	branch_history_table i_bht (
		.clock  (clock),
		.reset  (reset),
		.pc0    (pc),
		.pc1    (base0),
		.update (resolve),
		.taken0 (taken0),
		.taken1 (taken1)
	);

	next_pc_select i_next_pc (
		.clock          (clock),
		.reset          (reset),
		.decode0        (decode0),
		.decode1        (decode1),
		.inst0          (inst0),
		.inst1          (inst1),
		.taken0         (taken0),
		.taken1         (taken1),
		.jump_target0   (jump_target0),
		.jump_target1   (jump_target1),
		.mem_valid      (imem_valid),
		.dispatch_count (dispatch_count),
		.recover        (recover),
		.recover_addr   (recover_addr),
		.pc             (pc),
		.slot0          (slot0),
		.slot1          (slot1)
	);

endmodule

/* fetch_stage_checker.sv */
////////////////////////////////////////
// fetch stage checker
// slot ordering, idle and recover rules
////////////////////////////////////////

`timescale 1ns/10ps

module fetch_stage_checker (
	input logic                   clock,
	input logic                   reset,
	input logic                   imem_valid,
	input fetch_pkg::addr_t       imem_addr,
	input logic                   recover,
	input fetch_pkg::addr_t       recover_addr,
	input fetch_pkg::fetch_slot_t slot0,
	input fetch_pkg::fetch_slot_t slot1
);

	// slot 1 never stands alone
	slot_order: assert property (@(posedge clock) slot1.valid |-> slot0.valid)
		else $error("slot 1 valid while slot 0 is not");

	cond0_in_slot: assert property (@(posedge clock) slot0.cond_valid |-> slot0.valid)
		else $error("slot 0 cond_valid without valid");

	cond1_in_slot: assert property (@(posedge clock) slot1.cond_valid |-> slot1.valid)
		else $error("slot 1 cond_valid without valid");

	quiet_when_idle: assert property (@(posedge clock)
		(!imem_valid || reset) |-> !(slot0.valid || slot1.valid))
		else $error("slot valid with no memory data or in reset");

	recover_lands: assert property (@(posedge clock) disable iff (reset)
		recover |=> imem_addr == ($past(recover_addr) & ~64'h7))
		else $error("fetch did not resume at the recover address");

endmodule

bind fetch_stage fetch_stage_checker i_checker (
	.clock        (clock),
	.reset        (reset),
	.imem_valid   (imem_valid),
	.imem_addr    (imem_addr),
	.recover      (recover),
	.recover_addr (recover_addr),
	.slot0        (slot0),
	.slot1        (slot1)
);

/* fetch_stage_tb.sv */
////////////////////////////////////////
// fetch stage testbench
// directed tests against a memory model,
// shadow counters and the next pc rule
////////////////////////////////////////

`timescale 1ns/10ps

module fetch_stage_tb;

	localparam int clock_period  = 10;
	localparam int run_cycles    = 5 + 10 + 18 + 9 + 27 + 5 + 6;   // reset, then each test
	localparam int margin_cycles = 40;
	localparam logic [31:0] random_seed = 32'h440f_2f1f;
	localparam logic [5:0]  op_cond     = 6'h39;                  // a cond branch opcode
	localparam fetch_pkg::inst_t      jump_word = {fetch_pkg::op_jsr_grp, 26'h0};
	localparam fetch_pkg::bht_update_t no_update = '0;

	logic                       clock = 1'b0;
	logic                       reset;
	fetch_pkg::addr_t           imem_addr;
	fetch_pkg::mem_word_t       imem_data;
	logic                       imem_valid;
	fetch_pkg::dispatch_count_t dispatch_count;
	fetch_pkg::addr_t           jump_target0;
	fetch_pkg::addr_t           jump_target1;
	logic                       recover;
	fetch_pkg::addr_t           recover_addr;
	fetch_pkg::bht_update_t     resolve;
	fetch_pkg::fetch_slot_t     slot0;
	fetch_pkg::fetch_slot_t     slot1;

	fetch_pkg::inst_t    imem [256];                    // 1 KB program space, wraps
	fetch_pkg::counter_t shadow [fetch_pkg::bht_entries];   // reference counters
	fetch_pkg::addr_t    model_pc;
	fetch_pkg::addr_t    jump_a;                        // target buffer, slot 0
	fetch_pkg::addr_t    jump_b;                        // target buffer, slot 1
	int                  errors = 0;
	int                  checks = 0;

	always #(clock_period / 2) clock = ~clock;

	// memory answers in the same cycle
	assign imem_data = {imem[{imem_addr[9:3], 1'b1}], imem[{imem_addr[9:3], 1'b0}]};

	fetch_stage i_dut (
		.clock          (clock),
		.reset          (reset),
		.imem_addr      (imem_addr),
		.imem_data      (imem_data),
		.imem_valid     (imem_valid),
		.dispatch_count (dispatch_count),
		.jump_target0   (jump_target0),
		.jump_target1   (jump_target1),
		.recover        (recover),
		.recover_addr   (recover_addr),
		.resolve        (resolve),
		.slot0          (slot0),
		.slot1          (slot1)
	);

	////////////////////////////////////////
	// program and reference model
	////////////////////////////////////////
	task automatic load_filler();
		logic [31:0] r;
		for (int i = 0; i < 256; i++) begin
			r = $urandom;
			imem[i] = {r[31:26] % 6'd24, r[25:0]};   // opcodes 0..23, never a branch
		end
	endtask

	task automatic store_word(input fetch_pkg::addr_t addr, input fetch_pkg::inst_t word);
		imem[addr[9:2]] = word;
	endtask

	function automatic fetch_pkg::inst_t branch_word(input logic [5:0] op, input int disp);
		return {op, 5'd31, disp[20:0]};
	endfunction

	function automatic fetch_pkg::inst_t word_at(input fetch_pkg::addr_t addr);
		return imem[addr[9:2]];
	endfunction

	function automatic fetch_pkg::addr_t offset_target(input fetch_pkg::addr_t next,
			input fetch_pkg::inst_t word);
		return next + {{41{word[20]}}, word[20:0], 2'b00};   // disp in words
	endfunction

	function automatic void classify(input fetch_pkg::inst_t word, output logic unc,
			output logic cnd, output logic jmp);
		logic [5:0] op;
		op  = word[31:26];
		unc = (op == fetch_pkg::op_br) || (op == fetch_pkg::op_bsr);
		cnd = !unc && ((op[5:3] == 3'd6) || (op[5:3] == 3'd7));
		jmp = (op == fetch_pkg::op_jsr_grp);
	endfunction

	// expected slots and next pc for the current model pc
	function automatic void predict(input fetch_pkg::dispatch_count_t count, input logic mem_ok,
			output fetch_pkg::fetch_slot_t e0, output fetch_pkg::fetch_slot_t e1,
			output fetch_pkg::addr_t next_pc);
		fetch_pkg::addr_t base;
		fetch_pkg::addr_t addr1;
		fetch_pkg::addr_t tgt0;
		fetch_pkg::addr_t tgt1;
		fetch_pkg::inst_t w0;
		fetch_pkg::inst_t w1;
		logic             unc0;
		logic             cnd0;
		logic             jmp0;
		logic             unc1;
		logic             cnd1;
		logic             jmp1;
		logic             bit0;
		logic             bit1;
		logic             red0;
		logic             red1;
		base  = {model_pc[63:3], 3'b000};
		addr1 = model_pc + 4;
		w0    = model_pc[2] ? word_at(base + 4) : word_at(base);
		w1    = word_at(base + 4);
		classify(w0, unc0, cnd0, jmp0);
		classify(w1, unc1, cnd1, jmp1);
		bit0  = shadow[model_pc[fetch_pkg::bht_index_bits+1:2]][1];
		bit1  = shadow[addr1[fetch_pkg::bht_index_bits+1:2]][1];
		red0  = unc0 || jmp0 || (cnd0 && bit0);
		red1  = unc1 || jmp1 || (cnd1 && bit1);
		tgt0  = jmp0 ? jump_a : offset_target(model_pc + 4, w0);
		tgt1  = jmp1 ? jump_b : offset_target(model_pc + 8, w1);
		e0 = '0;
		e1 = '0;
		e0.valid       = mem_ok && (count != 2'd0);
		e0.inst        = w0;
		e0.npc         = model_pc + 4;
		e0.pred_taken  = cnd0 ? bit0 : (unc0 || jmp0);
		e0.pred_target = tgt0;
		e0.cond_valid  = e0.valid && cnd0;
		e1.valid       = e0.valid && !model_pc[2] && (count >= 2'd2) && !red0;
		e1.inst        = w1;
		e1.npc         = model_pc + 8;
		e1.pred_taken  = cnd1 ? bit1 : (unc1 || jmp1);
		e1.pred_target = tgt1;
		e1.cond_valid  = e1.valid && cnd1;
		next_pc = model_pc;                                   // stall holds
		if (e0.valid && red0) begin
			next_pc = tgt0;
		end else if (e1.valid) begin
			next_pc = red1 ? tgt1 : model_pc + 8;
		end else if (e0.valid) begin
			next_pc = model_pc + 4;
		end
	endfunction

	task automatic train(input fetch_pkg::addr_t addr, input logic taken);
		fetch_pkg::bht_index_t idx;
		idx = addr[fetch_pkg::bht_index_bits+1:2];
		if (taken && shadow[idx] != 2'd3) begin
			shadow[idx] = shadow[idx] + 2'd1;
		end else if (!taken && shadow[idx] != 2'd0) begin
			shadow[idx] = shadow[idx] - 2'd1;
		end
	endtask

	////////////////////////////////////////
	// checks and cycle driver
	////////////////////////////////////////
	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, want, got);
		end
	endtask

	task automatic compare_slot(input string name, input fetch_pkg::fetch_slot_t got,
			input fetch_pkg::fetch_slot_t want);
		check_value({name, ".valid"}, got.valid, want.valid);
		check_value({name, ".cond_valid"}, got.cond_valid, want.cond_valid);
		if (want.valid) begin
			check_value({name, ".inst"}, got.inst, want.inst);
			check_value({name, ".npc"}, got.npc, want.npc);
			check_value({name, ".pred_taken"}, got.pred_taken, want.pred_taken);
			check_value({name, ".pred_target"}, got.pred_target, want.pred_target);
		end
	endtask

	task automatic drive_cycle(input fetch_pkg::dispatch_count_t count, input logic mem_ok,
			input logic rec, input fetch_pkg::addr_t rec_addr,
			input fetch_pkg::bht_update_t upd);
		fetch_pkg::fetch_slot_t want0;
		fetch_pkg::fetch_slot_t want1;
		fetch_pkg::addr_t       next_pc;
		@(posedge clock);
		dispatch_count <= count;
		imem_valid     <= mem_ok;
		recover        <= rec;
		recover_addr   <= rec_addr;
		resolve        <= upd;                              // one cycle pulse
		jump_target0   <= jump_a;
		jump_target1   <= jump_b;
		@(negedge clock);                                   // outputs settled
		predict(count, mem_ok, want0, want1, next_pc);
		check_value("imem_addr", imem_addr, {model_pc[63:3], 3'b000});
		compare_slot("slot0", slot0, want0);
		compare_slot("slot1", slot1, want1);
		model_pc = rec ? rec_addr : next_pc;
		if (upd.valid) begin
			train(upd.pc, upd.taken);
		end
	endtask

	task automatic fetch_cycle(input fetch_pkg::dispatch_count_t count);
		drive_cycle(count, 1'b1, 1'b0, '0, no_update);
	endtask

	task automatic steer_to(input fetch_pkg::addr_t addr);
		drive_cycle(2'd0, 1'b1, 1'b1, addr, no_update);     // recover with decode idle
	endtask

	task automatic resolve_branch(input fetch_pkg::addr_t addr, input logic taken);
		fetch_pkg::bht_update_t upd;
		upd.valid = 1'b1;
		upd.pc    = addr;
		upd.taken = taken;
		drive_cycle(2'd0, 1'b1, 1'b0, '0, upd);
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////
	task automatic straight_line_fetch();
		load_filler();
		repeat (6) fetch_cycle(2'd2);
		steer_to(64'h104);                                  // odd word
		repeat (3) fetch_cycle(2'd2);
	endtask

	task automatic stall_and_throttle();
		logic [31:0] pick;
		load_filler();
		steer_to(64'h40);
		repeat (2) drive_cycle(2'd2, 1'b0, 1'b0, '0, no_update);   // memory not ready
		repeat (2) fetch_cycle(2'd0);
		fetch_cycle(2'd3);                                  // 3 acts as 2
		repeat (12) begin
			pick = 1 + ($urandom % 2);
			fetch_cycle(pick[1:0]);
		end
	endtask

	task automatic unconditional_branch();
		load_filler();
		store_word(64'h200, branch_word(fetch_pkg::op_br, 5));     // to 0x218
		store_word(64'h218, branch_word(fetch_pkg::op_br, -10));   // back to 0x1f4
		store_word(64'h304, branch_word(fetch_pkg::op_bsr, 3));    // slot 1, to 0x314
		steer_to(64'h200);
		repeat (3) fetch_cycle(2'd2);
		steer_to(64'h200);
		fetch_cycle(2'd1);                                  // single slot still redirects
		steer_to(64'h300);
		repeat (2) fetch_cycle(2'd2);
	endtask

	task automatic conditional_prediction();
		load_filler();
		store_word(64'h280, branch_word(op_cond, 8));       // slot 0, to 0x2a4
		store_word(64'h2c4, branch_word(op_cond, -4));      // slot 1, to 0x2b8
		steer_to(64'h280);
		fetch_cycle(2'd2);                                  // weakly not taken
		repeat (2) resolve_branch(64'h280, 1'b1);
		steer_to(64'h280);
		fetch_cycle(2'd2);
		resolve_branch(64'h280, 1'b1);                      // already strong
		for (int i = 0; i < 5; i++) begin
			resolve_branch(64'h280, 1'b0);
			steer_to(64'h280);
			fetch_cycle(2'd2);
		end
		repeat (2) resolve_branch(64'h2c4, 1'b1);
		steer_to(64'h2c0);
		fetch_cycle(2'd2);
		fetch_cycle(2'd0);                                  // land on 0x2b8 and idle
	endtask

	task automatic jump_redirect();
		load_filler();
		store_word(64'h340, jump_word);
		store_word(64'h364, jump_word);
		jump_a = 64'h3a0;
		jump_b = 64'h104;
		steer_to(64'h340);
		fetch_cycle(2'd2);
		steer_to(64'h360);
		repeat (2) fetch_cycle(2'd2);
		jump_a = '0;
		jump_b = '0;
	endtask

	task automatic recover_override();
		load_filler();
		store_word(64'h200, branch_word(fetch_pkg::op_br, 5));
		steer_to(64'h200);
		drive_cycle(2'd2, 1'b1, 1'b1, 64'h154, no_update);  // br pending
		fetch_cycle(2'd2);
		drive_cycle(2'd0, 1'b0, 1'b1, 64'h80, no_update);   // during a stall
		repeat (2) fetch_cycle(2'd2);
	endtask

	////////////////////////////////////////
	// run
	////////////////////////////////////////
	initial begin
		logic [31:0] seed_discard;
		seed_discard   = $urandom(random_seed);
		reset          = 1'b1;
		dispatch_count = 2'd2;                              // busy inputs during reset
		imem_valid     = 1'b1;
		jump_target0   = '0;
		jump_target1   = '0;
		recover        = 1'b0;
		recover_addr   = '0;
		resolve        = '0;
		jump_a         = '0;
		jump_b         = '0;
		model_pc       = '0;
		for (int i = 0; i < fetch_pkg::bht_entries; i++) begin
			shadow[i] = fetch_pkg::counter_reset;
		end
		load_filler();
		repeat (5) begin
			@(negedge clock);
			check_value("slot0.valid", slot0.valid, 1'b0);
			check_value("slot1.valid", slot1.valid, 1'b0);
		end
		@(posedge clock);
		reset          <= 1'b0;
		dispatch_count <= 2'd0;
		straight_line_fetch();
		stall_and_throttle();
		unconditional_branch();
		conditional_prediction();
		jump_redirect();
		recover_override();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// watchdog
	initial begin
		#((run_cycles + margin_cycles) * clock_period);
		$display("TIMEOUT: run did not finish within %0d cycles", run_cycles + margin_cycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* next_pc_select.sv */
////////////////////////////////////////
// next pc selector
// decides slot validity and redirect,
// fills the decode slots, holds the pc
////////////////////////////////////////

`timescale 1ns/10ps

module next_pc_select (
	input  logic                      clock,
	input  logic                      reset,
	input  fetch_pkg::slot_decode_t   decode0,        // slot 0 predecode
	input  fetch_pkg::slot_decode_t   decode1,        // slot 1 predecode
	input  fetch_pkg::inst_t          inst0,
	input  fetch_pkg::inst_t          inst1,
	input  logic                      taken0,         // table prediction, slot 0
	input  logic                      taken1,         // table prediction, slot 1
	input  fetch_pkg::addr_t          jump_target0,   // from target buffer
	input  fetch_pkg::addr_t          jump_target1,
	input  logic                      mem_valid,      // memory word usable
	input  fetch_pkg::dispatch_count_t dispatch_count,
	input  logic                      recover,        // back end redirect strobe
	input  fetch_pkg::addr_t          recover_addr,
	output fetch_pkg::addr_t          pc,             // current fetch pc
	output fetch_pkg::fetch_slot_t    slot0,
	output fetch_pkg::fetch_slot_t    slot1
);

	fetch_pkg::addr_t pc_reg;
	fetch_pkg::addr_t next_pc;
	fetch_pkg::addr_t npc0;       // pc + 4
	fetch_pkg::addr_t npc1;       // pc + 8
	fetch_pkg::addr_t target0;    // where slot 0 goes if it redirects
	fetch_pkg::addr_t target1;
	logic             fetch_go;   // something can be handed over
	logic             take_two;   // count of 2 or 3
	logic             odd_word;   // pc on the high half
	logic             redirect0;
	logic             redirect1;
	logic             valid0;
	logic             valid1;

	assign pc = pc_reg;

	assign npc0 = pc_reg + fetch_pkg::inst_bytes;
	assign npc1 = npc0 + fetch_pkg::inst_bytes;

	////////////////////////////////////////
	// slot validity
	////////////////////////////////////////
	assign fetch_go = mem_valid && !reset && (dispatch_count != 2'd0);
	assign take_two = dispatch_count[1];           // 3 behaves as 2
	assign odd_word = pc_reg[2];

	// taken-predicted cond, br/bsr or jump all leave the sequential path
	assign redirect0 = decode0.is_uncond || decode0.is_jump || (decode0.is_cond && taken0);
	assign redirect1 = decode1.is_uncond || decode1.is_jump || (decode1.is_cond && taken1);

	assign valid0 = fetch_go;                      // any nonzero count
	assign valid1 = fetch_go && !odd_word && take_two && !redirect0;

	assign target0 = decode0.is_jump ? jump_target0 : decode0.disp_target;
	assign target1 = decode1.is_jump ? jump_target1 : decode1.disp_target;

	////////////////////////////////////////
	// next pc
	////////////////////////////////////////
	always_comb begin
		next_pc = pc_reg;                          // stall holds
		if (valid0) begin
			if (redirect0) begin
				next_pc = target0;                 // first redirect wins
			end else if (valid1) begin
				next_pc = redirect1 ? target1 : npc1;
			end else begin
				next_pc = npc0;                    // single slot taken
			end
		end
	end

	////////////////////////////////////////
	// decode slots
	////////////////////////////////////////
	always_comb begin
		slot0.valid       = valid0;
		slot0.inst        = inst0;
		slot0.npc         = npc0;
		slot0.pred_taken  = redirect0;             // table bit, or 1 for br/jump
		slot0.pred_target = (valid0 && decode0.is_jump) ? jump_target0 : decode0.disp_target;
		slot0.cond_valid  = valid0 && decode0.is_cond;
	end

	always_comb begin
		slot1.valid       = valid1;
		slot1.inst        = inst1;
		slot1.npc         = npc1;
		slot1.pred_taken  = redirect1;
		slot1.pred_target = (valid1 && decode1.is_jump) ? jump_target1 : decode1.disp_target;
		slot1.cond_valid  = valid1 && decode1.is_cond;
	end

	////////////////////////////////////////
	// pc register
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_reg <= '0;                          // boot address
		end else if (recover) begin
			pc_reg <= recover_addr;                // beats any redirect or stall
		end else begin
			pc_reg <= next_pc;
		end
	end

endmodule

/* slot_predecode.sv */
////////////////////////////////////////
// slot predecoder
// classifies one instruction and forms
// its branch displacement target
////////////////////////////////////////

`timescale 1ns/10ps

module slot_predecode (
	input  fetch_pkg::inst_t        inst,    // instruction word
	input  fetch_pkg::addr_t        npc,     // address after the slot
	output fetch_pkg::slot_decode_t decode   // class flags and target
);

	logic [5:0]       opcode;     // major opcode field
	logic             uncond;
	logic             cond_grp;   // top three bits 6 or 7
	fetch_pkg::addr_t disp;       // sign extended, scaled by 4

	assign opcode = inst[31:26];

	////////////////////////////////////////
	// classification
	////////////////////////////////////////
	assign uncond = (opcode == fetch_pkg::op_br) ||
		(opcode == fetch_pkg::op_bsr);                       // br / bsr

	assign cond_grp = (opcode[5:3] == fetch_pkg::op_cond_grp0) ||
		(opcode[5:3] == fetch_pkg::op_cond_grp1);

	// br and bsr also sit in the cond groups, so they are taken out here
	assign decode.is_uncond = uncond;
	assign decode.is_cond   = cond_grp && !uncond;
	assign decode.is_jump   = (opcode == fetch_pkg::op_jsr_grp);  // target from outside

	////////////////////////////////////////
	// displacement target
	////////////////////////////////////////
	assign disp = {
		{(fetch_pkg::addr_bits - fetch_pkg::disp_bits - 2){inst[fetch_pkg::disp_bits-1]}},
		inst[fetch_pkg::disp_bits-1:0],
		2'b00                                                  // word to byte
	};

	assign decode.disp_target = npc + disp;   // relative to next pc

endmodule
